//--- hdl/icache_tag_defines.svh
/*
 * Tag array geometry for the two-way instruction cache
 * Lookup latency in rising edges
 */

`ifndef ICACHE_TAG_DEFINES_SVH
`define ICACHE_TAG_DEFINES_SVH

// Tag bits stored per way
`define TAG_WIDTH 23

// Set index bits, one SRAM word per set
`define INDEX_WIDTH 6
`define NUM_SETS 64

// Associativity
`define NUM_WAYS 2

// One way entry is valid plus tag
`define WAY_WIDTH 24

// Full set word, way 1 in the upper half
`define WORD_WIDTH 48

// Rising edges from request to registered response
`define LOOKUP_LATENCY 2

`endif

//--- hdl/icache_tag_pkg.sv
/*
 * Shared types for the tag path: way entry, set word union,
 * way index
 */

`default_nettype none

`include "icache_tag_defines.svh"

package icache_tag_pkg;

  // One way of a set
  // Valid sits in the top bit, tag below it
  typedef struct packed {
    logic                  valid;
    logic [`TAG_WIDTH-1:0] tag;
  } way_entry_t;

  // A whole SRAM word
  // Seen either as raw bits for the array port
  // or split per way, index 1 is the upper half
  typedef union packed {
    logic [`WORD_WIDTH-1:0]           raw;
    way_entry_t [`NUM_WAYS-1:0]       way;
  } set_word_u;

  // Names one of the two ways
  typedef logic way_idx_t;

endpackage

`default_nettype wire

//--- hdl/tag_sram_64x48.sv
/*
 * Behavioral 64x48 single-port tag SRAM with per-way write mask
 * Rising-edge input registers, falling-edge write and read
 */

`timescale 1ns/1ps
`default_nettype none

`include "icache_tag_defines.svh"

module tag_sram_64x48 (
  input  wire logic                    clk0,
  input  wire logic                    init,
  // Active low chip select and write enable
  input  wire logic                    csb,
  input  wire logic                    web,
  // One bit per way half of the word
  input  wire logic [`NUM_WAYS-1:0]    wmask,
  input  wire logic [`INDEX_WIDTH-1:0] addr,
  input  wire logic [`WORD_WIDTH-1:0]  din,
  output      logic [`WORD_WIDTH-1:0]  dout
);

  logic [`WORD_WIDTH-1:0] mem [0:`NUM_SETS-1];

  // Port registers
  logic                    csb_reg;
  logic                    web_reg;
  logic [`NUM_WAYS-1:0]    wmask_reg;
  logic [`INDEX_WIDTH-1:0] addr_reg;
  logic [`WORD_WIDTH-1:0]  din_reg;

  // Every input is captured on the rising edge
  // Idle after init, chip deselected
  always_ff @(posedge clk0 or posedge init) begin
    if (init) begin
      csb_reg   <= 1'b1;
      web_reg   <= 1'b1;
      wmask_reg <= '0;
      addr_reg  <= '0;
      din_reg   <= '0;
    end else begin
      csb_reg   <= csb;
      web_reg   <= web;
      wmask_reg <= wmask;
      addr_reg  <= addr;
      din_reg   <= din;
    end
  end

  // Masked write on the falling edge
  // init wipes the whole array, so every way reads invalid
  always_ff @(negedge clk0 or posedge init) begin
    if (init) begin
      for (int i = 0; i < `NUM_SETS; i++) begin
        mem[i] <= '0;
      end
    end else if (!csb_reg && !web_reg) begin
      for (int w = 0; w < `NUM_WAYS; w++) begin
        // Only the selected way half changes
        if (wmask_reg[w])
          mem[addr_reg][w*`WAY_WIDTH +: `WAY_WIDTH] <= din_reg[w*`WAY_WIDTH +: `WAY_WIDTH];
      end
    end
  end

  // Read on the same falling edge, dout holds otherwise
  always_ff @(negedge clk0 or posedge init) begin
    if (init) begin
      dout <= '0;
    end else if (!csb_reg && web_reg) begin
      dout <= mem[addr_reg];
    end
  end

endmodule

`default_nettype wire

//--- hdl/tag_lookup_issue.sv
/*
 * Request issue stage that registers the SRAM command per request
 * Builds fill words and carries the lookup tag to the resolver
 */

`timescale 1ns/1ps
`default_nettype none

`include "icache_tag_defines.svh"

module tag_lookup_issue (
  input  wire logic                     clk0,
  input  wire logic                     init,
  // Requester strobes
  input  wire logic                     req_valid,
  input  wire logic                     req_fill,
  input  wire logic [`INDEX_WIDTH-1:0]  req_index,
  input  wire logic [`TAG_WIDTH-1:0]    req_tag,
  input  wire icache_tag_pkg::way_idx_t req_way,
  // Registered SRAM port
  output      logic                     csb,
  output      logic                     web,
  output      logic [`NUM_WAYS-1:0]     wmask,
  output      logic [`INDEX_WIDTH-1:0]  addr,
  output      logic [`WORD_WIDTH-1:0]   din,
  // Lookup carry that lines up with dout at the resolver
  output      logic                     lookup_pending,
  output      logic [`TAG_WIDTH-1:0]    lookup_tag
);

  icache_tag_pkg::set_word_u fill_word;
  logic [`NUM_WAYS-1:0]      fill_mask;
  logic                      is_fill;
  logic                      is_lookup;

  // First carry stage lines up with the SRAM input registers
  logic                      pend_q1;
  logic [`TAG_WIDTH-1:0]     tag_q1;

  assign is_fill   = req_valid && req_fill;
  assign is_lookup = req_valid && !req_fill;

  // New valid entry placed in the named way only
  // The other half stays zero and is masked off anyway
  always_comb begin
    fill_word.raw                = '0;
    fill_word.way[req_way].valid = 1'b1;
    fill_word.way[req_way].tag   = req_tag;
    fill_mask                    = '0;
    fill_mask[req_way]           = 1'b1;
  end

  // Command strobes
  always_ff @(posedge clk0 or posedge init) begin
    if (init) begin
      csb   <= 1'b1;
      web   <= 1'b1;
      wmask <= '0;
    end else begin
      csb   <= !req_valid;
      web   <= !is_fill;
      // Lookups never write, so no way is selected
      wmask <= is_fill ? fill_mask : '0;
    end
  end

  // Address and write data
  always_ff @(posedge clk0 or posedge init) begin
    if (init) begin
      addr <= '0;
      din  <= '0;
    end else if (req_valid) begin
      addr <= req_index;
      din  <= fill_word.raw;
    end
  end

  // Pending bit through both stages
  always_ff @(posedge clk0 or posedge init) begin
    if (init) begin
      pend_q1        <= 1'b0;
      lookup_pending <= 1'b0;
    end else begin
      pend_q1        <= is_lookup;
      lookup_pending <= pend_q1;
    end
  end

  // Tag rides along with the pending bit
  always_ff @(posedge clk0 or posedge init) begin
    if (init) begin
      tag_q1     <= '0;
      lookup_tag <= '0;
    end else begin
      tag_q1     <= req_tag;
      lookup_tag <= tag_q1;
    end
  end

endmodule

`default_nettype wire

//--- hdl/hit_resolve.sv
/*
 * Hit resolver: decodes the set word, compares both ways
 * against the carried tag, registers the response
 */

`timescale 1ns/1ps
`default_nettype none

`include "icache_tag_defines.svh"

module hit_resolve (
  input  wire logic                     clk0,
  input  wire logic                     init,
  // Set word from the SRAM, valid from the falling edge
  input  wire logic [`WORD_WIDTH-1:0]   dout,
  // Carried lookup
  input  wire logic                     lookup_pending,
  input  wire logic [`TAG_WIDTH-1:0]    lookup_tag,
  // Response, one cycle wide
  output      logic                     rsp_valid,
  output      logic                     rsp_hit,
  output      icache_tag_pkg::way_idx_t rsp_way
);

  icache_tag_pkg::set_word_u rd_word;
  logic [`NUM_WAYS-1:0]      way_hit;
  logic                      any_hit;
  icache_tag_pkg::way_idx_t  hit_way;

  // Split the raw word into its two way entries
  always_comb begin
    rd_word.raw = dout;
  end

  // Per-way compare, needs valid and an exact tag
  always_comb begin
    for (int w = 0; w < `NUM_WAYS; w++) begin
      way_hit[w] = rd_word.way[w].valid && (rd_word.way[w].tag == lookup_tag);
    end
  end

  assign any_hit = |way_hit;

  // Way 0 has priority
  // Miss also reports way 0
  always_comb begin
    if (way_hit[0])
      hit_way = 1'b0;
    else if (way_hit[1])
      hit_way = 1'b1;
    else
      hit_way = 1'b0;
  end

  // Registered at the second rising edge after the request
  // Nothing is reported for idle cycles or fills
  always_ff @(posedge clk0 or posedge init) begin
    if (init) begin
      rsp_valid <= 1'b0;
      rsp_hit   <= 1'b0;
      rsp_way   <= 1'b0;
    end else begin
      rsp_valid <= lookup_pending;
      rsp_hit   <= lookup_pending && any_hit;
      rsp_way   <= lookup_pending ? hit_way : 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- hdl/icache_tag_top.sv
/*
 * Tag side of the two-way instruction cache
 * Issue stage, tag SRAM and hit resolver
 */

`timescale 1ns/1ps
`default_nettype none

`include "icache_tag_defines.svh"

module icache_tag_top (
  input  wire logic                     clk0,
  input  wire logic                     init,
  input  wire logic                     req_valid,
  input  wire logic                     req_fill,
  input  wire logic [`INDEX_WIDTH-1:0]  req_index,
  input  wire logic [`TAG_WIDTH-1:0]    req_tag,
  input  wire icache_tag_pkg::way_idx_t req_way,
  output      logic                     rsp_valid,
  output      logic                     rsp_hit,
  output      icache_tag_pkg::way_idx_t rsp_way
);

  // SRAM port
  logic                    csb;
  logic                    web;
  logic [`NUM_WAYS-1:0]    wmask;
  logic [`INDEX_WIDTH-1:0] addr;
  logic [`WORD_WIDTH-1:0]  din;
  logic [`WORD_WIDTH-1:0]  dout;

  // Lookup carry into the resolver
  logic                    lookup_pending;
  logic [`TAG_WIDTH-1:0]   lookup_tag;

  tag_lookup_issue u_issue (
    .clk0           (clk0),
    .init           (init),
    .req_valid      (req_valid),
    .req_fill       (req_fill),
    .req_index      (req_index),
    .req_tag        (req_tag),
    .req_way        (req_way),
    .csb            (csb),
    .web            (web),
    .wmask          (wmask),
    .addr           (addr),
    .din            (din),
    .lookup_pending (lookup_pending),
    .lookup_tag     (lookup_tag)
  );

  tag_sram_64x48 u_sram (
    .clk0  (clk0),
    .init  (init),
    .csb   (csb),
    .web   (web),
    .wmask (wmask),
    .addr  (addr),
    .din   (din),
    .dout  (dout)
  );

  hit_resolve u_resolve (
    .clk0           (clk0),
    .init           (init),
    .dout           (dout),
    .lookup_pending (lookup_pending),
    .lookup_tag     (lookup_tag),
    .rsp_valid      (rsp_valid),
    .rsp_hit        (rsp_hit),
    .rsp_way        (rsp_way)
  );

endmodule

`default_nettype wire

//--- verification/icache_tag_tb.sv
/*
 * Testbench for the two-way instruction cache tag side
 * Clock, reset, LFSR stimulus, reference model, compare tasks, watchdog
 */

`timescale 1ns/1ps
`default_nettype none

`include "icache_tag_defines.svh"

module icache_tag_tb;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 5;
  // Request counts per test
  localparam int N_COLD       = 24;
  localparam int N_MIX        = 300;
  localparam int TOTAL_REQS   = N_COLD + 2 + 4 + 1 + N_MIX + 3;
  localparam int WATCHDOG_CYC = RESET_CYCLES + TOTAL_REQS + `LOOKUP_LATENCY + 50;

  logic                     clk0;
  logic                     init;
  logic                     req_valid;
  logic                     req_fill;
  logic [`INDEX_WIDTH-1:0]  req_index;
  logic [`TAG_WIDTH-1:0]    req_tag;
  icache_tag_pkg::way_idx_t req_way;
  logic                     rsp_valid;
  logic                     rsp_hit;
  icache_tag_pkg::way_idx_t rsp_way;

  // Reference copy of the tag array
  logic                     model_valid [0:`NUM_SETS-1][0:`NUM_WAYS-1];
  logic [`TAG_WIDTH-1:0]    model_tag   [0:`NUM_SETS-1][0:`NUM_WAYS-1];

  // Expected responses, in issue order
  logic                     exp_hit_q  [$];
  icache_tag_pkg::way_idx_t exp_way_q  [$];
  int                       exp_edge_q [$];
  string                    exp_name_q [$];

  int                       edge_count;
  logic [31:0]              lfsr_state;

  icache_tag_top DUT (
    .clk0      (clk0),
    .init      (init),
    .req_valid (req_valid),
    .req_fill  (req_fill),
    .req_index (req_index),
    .req_tag   (req_tag),
    .req_way   (req_way),
    .rsp_valid (rsp_valid),
    .rsp_hit   (rsp_hit),
    .rsp_way   (rsp_way)
  );

  always #(CLK_PERIOD / 2) clk0 = ~clk0;

  // Rising edge count, stable at the falling edge
  always @(posedge clk0) edge_count <= edge_count + 1;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  // Expected {hit, way}, way 0 first, way 0 on a miss
  function automatic logic [1:0] ref_lookup(input logic [`INDEX_WIDTH-1:0] idx,
                                            input logic [`TAG_WIDTH-1:0] tag);
    logic hit0;
    logic hit1;
    hit0 = model_valid[idx][0] && (model_tag[idx][0] == tag);
    hit1 = model_valid[idx][1] && (model_tag[idx][1] == tag);
    if (hit0)
      return 2'b10;
    else if (hit1)
      return 2'b11;
    else
      return 2'b00;
  endfunction

  task automatic check_hit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("FAILED %s: hit expected %0b, actual %0b", name, exp, act);
      $display("SOME TESTS FAILED");
      $fatal(1, "hit mismatch");
    end
  endtask

  task automatic check_way(input string name, input icache_tag_pkg::way_idx_t exp,
                           input icache_tag_pkg::way_idx_t act);
    if (exp !== act) begin
      $display("FAILED %s: way expected %0b, actual %0b", name, exp, act);
      $display("SOME TESTS FAILED");
      $fatal(1, "way mismatch");
    end
  endtask

  task automatic check_edge(input string name, input int exp, input int act);
    if (exp != act) begin
      $display("FAILED %s: response edge expected %0d, actual %0d", name, exp, act);
      $display("SOME TESTS FAILED");
      $fatal(1, "latency mismatch");
    end
  endtask

  // Drive one lookup, queue what should come back
  task automatic issue_lookup(input string name, input logic [`INDEX_WIDTH-1:0] idx,
                              input logic [`TAG_WIDTH-1:0] tag);
    logic [1:0] exp;
    req_valid = 1'b1;
    req_fill  = 1'b0;
    req_index = idx;
    req_tag   = tag;
    req_way   = 1'b0;
    exp = ref_lookup(idx, tag);
    exp_hit_q.push_back(exp[1]);
    exp_way_q.push_back(exp[0]);
    // Captured at the next edge, answered LOOKUP_LATENCY edges later
    exp_edge_q.push_back(edge_count + 1 + `LOOKUP_LATENCY);
    exp_name_q.push_back(name);
    @(negedge clk0);
  endtask

  // Drive one fill and update the model
  task automatic issue_fill(input logic [`INDEX_WIDTH-1:0] idx,
                            input logic [`TAG_WIDTH-1:0] tag,
                            input icache_tag_pkg::way_idx_t way);
    req_valid = 1'b1;
    req_fill  = 1'b1;
    req_index = idx;
    req_tag   = tag;
    req_way   = way;
    model_valid[idx][way] = 1'b1;
    model_tag[idx][way]   = tag;
    @(negedge clk0);
  endtask

  // Responses sampled away from the rising edge
  always @(negedge clk0) begin
    if (!init && rsp_valid) begin
      if (exp_hit_q.size() == 0) begin
        $display("A response arrived while no lookup was outstanding");
        $display("SOME TESTS FAILED");
        $fatal(1, "unexpected response");
      end else begin
        check_hit(exp_name_q[0], exp_hit_q[0], rsp_hit);
        check_way(exp_name_q[0], exp_way_q[0], rsp_way);
        check_edge(exp_name_q[0], exp_edge_q[0], edge_count);
        void'(exp_hit_q.pop_front());
        void'(exp_way_q.pop_front());
        void'(exp_edge_q.pop_front());
        void'(exp_name_q.pop_front());
      end
    end
  end

  // Watchdog
  initial begin
    #(WATCHDOG_CYC * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYC);
    $display("SOME TESTS FAILED");
    $fatal(1, "timeout");
  end

  initial begin
    logic [31:0] r_fill;
    logic [31:0] r_way;
    logic [31:0] r_set;
    logic [31:0] r_tag;
    clk0       = 1'b0;
    init       = 1'b1;
    req_valid  = 1'b0;
    req_fill   = 1'b0;
    req_index  = '0;
    req_tag    = '0;
    req_way    = 1'b0;
    edge_count = 0;
    lfsr_state = 32'h39db_5d5d;
    for (int s = 0; s < `NUM_SETS; s++) begin
      for (int w = 0; w < `NUM_WAYS; w++) begin
        model_valid[s][w] = 1'b0;
        model_tag[s][w]   = '0;
      end
    end
    repeat (RESET_CYCLES) @(posedge clk0);
    @(negedge clk0);
    init = 1'b0;

    // Cold array, every lookup misses
    for (int i = 0; i < N_COLD; i++) begin
      take_bits(`INDEX_WIDTH, r_set);
      take_bits(`TAG_WIDTH, r_tag);
      issue_lookup("cold_miss", r_set[`INDEX_WIDTH-1:0], r_tag[`TAG_WIDTH-1:0]);
    end

    // Fill then lookup on the very next cycle
    issue_fill(6'd5, 23'h2a_1357, 1'b0);
    issue_lookup("fill_way0_hit", 6'd5, 23'h2a_1357);

    // Way 1 fill must not disturb way 0
    issue_fill(6'd17, 23'h12_3456, 1'b0);
    issue_fill(6'd17, 23'h55_aaaa, 1'b1);
    issue_lookup("mask_way0", 6'd17, 23'h12_3456);
    issue_lookup("mask_way1", 6'd17, 23'h55_aaaa);

    // Tag held by neither way
    issue_lookup("foreign_tag", 6'd17, 23'h7f_0001);

    // Back-to-back random mix over a small set and tag pool
    for (int i = 0; i < N_MIX; i++) begin
      take_bits(1, r_fill);
      take_bits(1, r_way);
      take_bits(3, r_set);
      take_bits(2, r_tag);
      if (r_fill[0])
        issue_fill({3'b000, r_set[2:0]}, {21'h0f0f0f, r_tag[1:0]}, r_way[0]);
      else
        issue_lookup("random_mix", {3'b000, r_set[2:0]}, {21'h0f0f0f, r_tag[1:0]});
    end

    // Same tag in both ways, way 0 reported
    issue_fill(6'd42, 23'h3c_c3c3, 1'b0);
    issue_fill(6'd42, 23'h3c_c3c3, 1'b1);
    issue_lookup("dual_way_prio", 6'd42, 23'h3c_c3c3);

    req_valid = 1'b0;
    req_fill  = 1'b0;
    // Drain, then a few idle cycles to catch stray responses
    while (exp_hit_q.size() != 0) @(negedge clk0);
    repeat (4) @(negedge clk0);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+hdl
hdl/icache_tag_pkg.sv
hdl/tag_sram_64x48.sv
hdl/tag_lookup_issue.sv
hdl/hit_resolve.sv
hdl/icache_tag_top.sv
verification/icache_tag_tb.sv

//--- Makefile
# Verilator simulation of the instruction cache tag side

TOOL  = verilator
FLAGS = --binary --timing -j 0
TOP   = icache_tag_tb
FLIST = flist.f

.PHONY: sim clean

# Build and run; a $fatal in the testbench gives a failing exit status
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
